// ==== Bender.yml ====
package:
  name: audio_effects

sources:
  - hdl/audio_pkg.sv
  - hdl/i2s_pkg.sv
  - hdl/sample_rate_strobe.sv
  - hdl/gain_control.sv
  - hdl/effects_pipeline.sv
  - hdl/i2s_transmitter.sv
  - hdl/audio_effects_top.sv
  - target: simulation
    files:
      - testbench/audio_effects_properties.sv
      - testbench/audio_effects_tb.sv

// ==== hdl/audio_effects_top.sv ====
// Audio effects top, strobe, gain controls, effects pipeline and I2S output
`timescale 1ns/1ns
`default_nettype none

module audio_effects_top (
	input wire clk,
	input wire rst,
	input wire pre_step_enable,
	input wire post_step_enable,
	input wire up,
	input wire down,
	input wire overdrive,
	input wire bypass,
	input wire audio_pkg::sample_t sample_in,
	output audio_pkg::gain_t pre_gain,
	output audio_pkg::gain_t post_gain,
	output logic processed_valid,
	output audio_pkg::sample_t processed_sample,
	output logic mclk,
	output logic bclk,
	output logic lrclk,
	output logic sdata
);

	logic sample_strobe;

	sample_rate_strobe strobe_i (
		.clk(clk),
		.rst(rst),
		.sample_strobe(sample_strobe)
	);

	// Both gains share the keys, each has its own enable
	gain_control #(
		.reset_gain(audio_pkg::unity_gain)
	) pre_gain_i (
		.clk(clk),
		.rst(rst),
		.step_enable(pre_step_enable),
		.up(up),
		.down(down),
		.gain(pre_gain)
	);

	gain_control #(
		.reset_gain(audio_pkg::unity_gain)
	) post_gain_i (
		.clk(clk),
		.rst(rst),
		.step_enable(post_step_enable),
		.up(up),
		.down(down),
		.gain(post_gain)
	);

	effects_pipeline effects_i (
		.clk(clk),
		.rst(rst),
		.in_valid(sample_strobe),
		.overdrive(overdrive),
		.bypass(bypass),
		.sample_in(sample_in),
		.pre_gain(pre_gain),
		.post_gain(post_gain),
		.out_valid(processed_valid),
		.out_sample(processed_sample)
	);

	i2s_transmitter i2s_i (
		.clk(clk),
		.rst(rst),
		.sample_valid(processed_valid),
		.sample(processed_sample),
		.mclk(mclk),
		.bclk(bclk),
		.lrclk(lrclk),
		.sdata(sdata)
	);

endmodule

`default_nettype wire

// ==== hdl/audio_pkg.sv ====
// Audio package with the sample and gain types and the effect constants
`default_nettype none

package audio_pkg;

	// Signed audio sample, two's complement
	typedef logic signed [15:0] sample_t;

	// Unsigned gain in Q12.4
	typedef logic [15:0] gain_t;

	localparam int gain_frac_bits = 4; // Fraction bits of gain_t

	// One LSB per step, so 1/16 of unity
	localparam gain_t gain_step = 16'd1;

	localparam int gain_repeat_cycles = 64; // Power of two, clk cycles between repeats

	// 1.0 in Q12.4
	localparam gain_t unity_gain = 16'd16;

	// Overdrive clips symmetrically at this level
	localparam sample_t overdrive_limit = 16'sd8192;

endpackage

`default_nettype wire

// ==== hdl/effects_pipeline.sv ====
// Effects pipeline, input gain then overdrive clip then bypass select and output gain
`timescale 1ns/1ns
`default_nettype none

module effects_pipeline (
	input wire clk,
	input wire rst,
	input wire in_valid,
	input wire overdrive,
	input wire bypass,
	input wire audio_pkg::sample_t sample_in,
	input wire audio_pkg::gain_t pre_gain,
	input wire audio_pkg::gain_t post_gain,
	output logic out_valid,
	output audio_pkg::sample_t out_sample
);

	localparam audio_pkg::sample_t sample_max = 16'sh7fff;
	localparam audio_pkg::sample_t sample_min = 16'sh8000;
	localparam audio_pkg::sample_t clip_hi = audio_pkg::overdrive_limit;
	localparam audio_pkg::sample_t clip_lo = -audio_pkg::overdrive_limit;

	// Q12.4 multiply, drop the fraction, clamp to the sample range
	function automatic audio_pkg::sample_t scale(input audio_pkg::sample_t value,
		input audio_pkg::gain_t gain);
		logic signed [32:0] product;
		product = value * $signed({1'b0, gain});
		product = product >>> audio_pkg::gain_frac_bits;
		if (product > sample_max)
			return sample_max;
		if (product < sample_min)
			return sample_min;
		return $signed(product[15:0]);
	endfunction

	logic s1_valid;
	logic s2_valid;
	audio_pkg::sample_t s1_sample;
	audio_pkg::sample_t s1_raw;
	audio_pkg::sample_t s2_sample;
	audio_pkg::sample_t s2_raw;
	logic s1_overdrive;
	logic s1_bypass;
	logic s2_bypass;
	audio_pkg::gain_t s1_post_gain;
	audio_pkg::gain_t s2_post_gain;
	audio_pkg::sample_t clipped;
	audio_pkg::sample_t chosen;

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
			s2_valid <= s1_valid;
			out_valid <= s2_valid;
		end
	end

	// Overdrive clipper
	always_comb begin
		clipped = s1_sample;
		if (s1_overdrive && s1_sample > clip_hi)
			clipped = clip_hi;
		else if (s1_overdrive && s1_sample < clip_lo)
			clipped = clip_lo;
	end

	assign chosen = s2_bypass ? s2_raw : s2_sample; // Raw input skips both effects

	// Controls are captured with the sample and travel with it
	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_sample <= scale(sample_in, pre_gain);
			s1_raw <= sample_in;
			s1_overdrive <= overdrive;
			s1_bypass <= bypass;
			s1_post_gain <= post_gain;
		end
		if (s1_valid) begin
			s2_sample <= clipped;
			s2_raw <= s1_raw;
			s2_bypass <= s1_bypass;
			s2_post_gain <= s1_post_gain;
		end
		if (s2_valid)
			out_sample <= scale(chosen, s2_post_gain);
	end

endmodule

`default_nettype wire

// ==== hdl/gain_control.sv ====
// Gain control, a saturating gain register stepped by held keys with auto repeat
`timescale 1ns/1ns
`default_nettype none

module gain_control #(
	parameter audio_pkg::gain_t reset_gain = audio_pkg::unity_gain
) (
	input wire clk,
	input wire rst,
	input wire step_enable,
	input wire up,
	input wire down,
	output audio_pkg::gain_t gain
);

	localparam int timer_bits = $clog2(audio_pkg::gain_repeat_cycles) + 1;
	// Top bit set means a step is due
	localparam logic [timer_bits-1:0] timer_armed = timer_bits'(audio_pkg::gain_repeat_cycles);
	localparam audio_pkg::gain_t gain_max = '1;

	logic [timer_bits-1:0] timer;
	audio_pkg::gain_t gain_next;

	// Saturating step, up wins over down
	always_comb begin
		gain_next = gain;
		if (up) begin
			if (gain > gain_max - audio_pkg::gain_step)
				gain_next = gain_max;
			else
				gain_next = gain + audio_pkg::gain_step;
		end else if (down) begin
			if (gain < audio_pkg::gain_step)
				gain_next = '0;
			else
				gain_next = gain - audio_pkg::gain_step;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			gain <= reset_gain;
			timer <= timer_armed;
		end else if (!step_enable) begin
			timer <= timer_armed; // Next enable steps at once
		end else if (timer[timer_bits-1]) begin
			if (up || down) begin
				gain <= gain_next;
				timer <= timer_bits'(1); // Reaches armed again after gain_repeat_cycles
			end
		end else begin
			timer <= timer + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/i2s_pkg.sv ====
// I2S package with the clock ratios and the frame layout constants
`default_nettype none

package i2s_pkg;

	// One frame per sample, so the strobe period equals the frame length
	localparam int clks_per_sample = 256;

	// bclk periods per channel, left and right make one frame
	localparam int slot_bits = 32;

	// Position inside a frame, wraps at clks_per_sample
	typedef logic [7:0] frame_count_t;

endpackage

`default_nettype wire

// ==== hdl/i2s_transmitter.sv ====
// I2S transmitter, derives mclk, bclk and lrclk and shifts out the same sample on both channels
`timescale 1ns/1ns
`default_nettype none

module i2s_transmitter (
	input wire clk,
	input wire rst,
	input wire sample_valid,
	input wire audio_pkg::sample_t sample,
	output logic mclk,
	output logic bclk,
	output logic lrclk,
	output logic sdata
);

	localparam int lrclk_bit = $clog2(i2s_pkg::clks_per_sample) - 1;
	// 64 bclk periods per frame
	localparam int bclk_bit = $clog2(i2s_pkg::clks_per_sample / (2 * i2s_pkg::slot_bits)) - 1;
	localparam int slot_width = $clog2(i2s_pkg::slot_bits);
	localparam int data_bits = $bits(audio_pkg::sample_t);

	i2s_pkg::frame_count_t count;
	logic active;
	audio_pkg::sample_t latched;
	logic [slot_width-1:0] slot;
	logic slot_data;

	assign slot = count[bclk_bit+slot_width:bclk_bit+1]; // bclk period inside the channel

	// Slot 0 empty, then MSB first, zero fill after the LSB
	always_comb begin
		slot_data = 1'b0;
		if (slot != '0 && slot <= data_bits)
			slot_data = latched[data_bits-slot];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
			active <= 1'b0;
			mclk <= 1'b0;
			bclk <= 1'b0;
			lrclk <= 1'b0;
			sdata <= 1'b0;
		end else begin
			if (sample_valid) begin
				count <= '0; // Frame restarts on each sample
				active <= 1'b1;
			end else if (active) begin
				count <= count + 1'b1;
			end
			mclk <= count[0];
			bclk <= count[bclk_bit];
			lrclk <= count[lrclk_bit]; // Left channel while low
			// Second low cycle of each bclk period
			if (active && count[bclk_bit:0] == 1)
				sdata <= slot_data;
		end
	end

	always_ff @(posedge clk) begin
		if (sample_valid)
			latched <= sample;
	end

endmodule

`default_nettype wire

// ==== hdl/sample_rate_strobe.sv ====
// Sample rate strobe, one clk-wide pulse every clks_per_sample cycles
`timescale 1ns/1ns
`default_nettype none

module sample_rate_strobe (
	input wire clk,
	input wire rst,
	output logic sample_strobe
);

	localparam int count_bits = $clog2(i2s_pkg::clks_per_sample);
	localparam logic [count_bits-1:0] reload = count_bits'(i2s_pkg::clks_per_sample - 1);

	logic [count_bits-1:0] count;

	// Down counter, first zero comes clks_per_sample cycles after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= reload;
		end else if (count == '0) begin
			count <= reload;
		end else begin
			count <= count - 1'b1;
		end
	end

	assign sample_strobe = (count == '0); // Low while reloaded

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/audio_pkg.sv
hdl/i2s_pkg.sv
hdl/sample_rate_strobe.sv
hdl/gain_control.sv
hdl/effects_pipeline.sv
hdl/i2s_transmitter.sv
hdl/audio_effects_top.sv
testbench/audio_effects_properties.sv
testbench/audio_effects_tb.sv

// ==== testbench/audio_effects_properties.sv ====
// I2S transmitter assertions on bclk, lrclk and sdata alignment and on the idle state
`timescale 1ns/1ns
`default_nettype none

module audio_effects_properties (
	input wire clk,
	input wire rst,
	input wire active,
	input wire mclk,
	input wire bclk,
	input wire lrclk,
	input wire sdata
);

	logic violation = 1'b0; // Sticky, read by the testbench at the end

	// Receiver samples on the rising bclk edge
	sdata_stable_a: assert property (@(posedge clk) disable iff (rst)
		$changed(sdata) |-> !bclk) else begin
		$error("sdata changed while bclk was high");
		violation = 1'b1;
	end

	lrclk_edge_a: assert property (@(posedge clk) disable iff (rst)
		$changed(lrclk) |-> $fell(bclk)) else begin
		$error("lrclk changed away from a falling bclk edge");
		violation = 1'b1;
	end

	// Quiet until the first sample arrives
	idle_low_a: assert property (@(posedge clk) disable iff (rst)
		!active |-> !(mclk || bclk || lrclk || sdata)) else begin
		$error("I2S outputs toggled before the first sample");
		violation = 1'b1;
	end

endmodule

bind i2s_transmitter audio_effects_properties props_i (.*);

`default_nettype wire

// ==== testbench/audio_effects_tb.sv ====
// Audio effects testbench, directed tests of gains, overdrive, bypass and the I2S frame
`timescale 1ns/1ns
`default_nettype none

module audio_effects_tb;

	localparam int valid_timeout = 2 * i2s_pkg::clks_per_sample;

	logic clk;
	logic rst;
	logic pre_step_enable;
	logic post_step_enable;
	logic up;
	logic down;
	logic overdrive;
	logic bypass;
	audio_pkg::sample_t sample_in;
	audio_pkg::gain_t pre_gain;
	audio_pkg::gain_t post_gain;
	logic processed_valid;
	audio_pkg::sample_t processed_sample;
	logic mclk;
	logic bclk;
	logic lrclk;
	logic sdata;
	audio_pkg::gain_t exp_pre; // Gains the tests expect
	audio_pkg::gain_t exp_post;

	audio_effects_top dut_i (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk; // 10 ns period

	task automatic abort(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "Stopped at %0t ns", $time);
	endtask

	task automatic check_sample(input string name, input audio_pkg::sample_t got,
		input audio_pkg::sample_t expected);
		if (got !== expected)
			abort($sformatf("MISMATCH at %0t ns: %s got %0d, expected %0d",
				$time, name, got, expected));
	endtask

	task automatic check_gain(input string name, input audio_pkg::gain_t got,
		input audio_pkg::gain_t expected);
		if (got !== expected)
			abort($sformatf("MISMATCH at %0t ns: %s got %0d, expected %0d",
				$time, name, got, expected));
	endtask

	task automatic check_level(input string name, input logic got, input logic expected);
		if (got !== expected)
			abort($sformatf("MISMATCH at %0t ns: %s got %0b, expected %0b",
				$time, name, got, expected));
	endtask

	// I2S assertion failures end the run at once
	always @(negedge clk) begin
		if (dut_i.i2s_i.props_i.violation)
			abort("An I2S timing assertion failed");
	end

	// Q12.4 gain, floor of the shifted product, clamped to 16 bits
	function automatic audio_pkg::sample_t scaled(input audio_pkg::sample_t x,
		input audio_pkg::gain_t g);
		longint p;
		p = (longint'(x) * longint'(g)) >>> audio_pkg::gain_frac_bits;
		if (p > 32767)
			p = 32767;
		else if (p < -32768)
			p = -32768;
		return audio_pkg::sample_t'(p);
	endfunction

	task automatic wait_valid(input bit from_reset);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > valid_timeout)
				abort("Timeout while waiting for processed_valid");
			if (from_reset && (mclk || bclk || lrclk || sdata))
				abort("I2S outputs are not low before the first sample");
		end while (!processed_valid);
		if (from_reset && cycles < i2s_pkg::clks_per_sample)
			abort("processed_valid came before the first sample strobe");
	endtask

	task automatic hold_keys(input logic pre_en, input logic post_en, input logic up_key,
		input logic down_key, input int cycles);
		pre_step_enable = pre_en;
		post_step_enable = post_en;
		up = up_key;
		down = down_key;
		repeat (cycles) @(negedge clk);
		pre_step_enable = 1'b0;
		post_step_enable = 1'b0;
		up = 1'b0;
		down = 1'b0;
	endtask

	task automatic run_sample(input audio_pkg::sample_t x, output audio_pkg::sample_t expected);
		audio_pkg::sample_t mid;
		sample_in = x;
		mid = scaled(x, exp_pre);
		if (overdrive && mid > audio_pkg::overdrive_limit)
			mid = audio_pkg::overdrive_limit;
		else if (overdrive && mid < -audio_pkg::overdrive_limit)
			mid = -audio_pkg::overdrive_limit;
		expected = scaled(bypass ? x : mid, exp_post);
		wait_valid(1'b0); // Older sample, or already this one
		wait_valid(1'b0);
		check_sample("processed_sample", processed_sample, expected);
	endtask

	// Rebuilds both channels from sdata on rising bclk
	task automatic decode_frame(input audio_pkg::sample_t expected);
		audio_pkg::sample_t channel[2];
		logic prev_bclk;
		logic prev_mclk;
		int rises;
		int cycles;
		int slot;
		rises = 0;
		cycles = 0;
		prev_bclk = bclk;
		prev_mclk = mclk;
		while (rises < 2 * i2s_pkg::slot_bits) begin
			@(negedge clk);
			cycles++;
			if (cycles > valid_timeout)
				abort("Timeout while decoding the I2S frame");
			check_level("mclk", mclk, !prev_mclk); // Half the clk rate
			if (bclk && !prev_bclk) begin
				slot = rises % i2s_pkg::slot_bits;
				// Left channel while low
				check_level("lrclk", lrclk, rises >= i2s_pkg::slot_bits);
				if (slot >= 1 && slot <= $bits(audio_pkg::sample_t))
					channel[rises / i2s_pkg::slot_bits][$bits(audio_pkg::sample_t) - slot] = sdata;
				rises++;
			end
			prev_bclk = bclk;
			prev_mclk = mclk;
		end
		check_sample("i2s left channel", channel[0], expected);
		check_sample("i2s right channel", channel[1], expected);
	endtask

	task automatic test_reset_state();
		wait_valid(1'b1);
		check_gain("pre_gain", pre_gain, audio_pkg::unity_gain);
		check_gain("post_gain", post_gain, audio_pkg::unity_gain);
	endtask

	task automatic test_overdrive();
		audio_pkg::sample_t expected;
		overdrive = 1'b1;
		run_sample(16'sd20000, expected);
		run_sample(-16'sd20000, expected);
		run_sample(16'sd1000, expected); // Inside the limit
		overdrive = 1'b0;
	endtask

	// First step at once, then one per repeat period
	task automatic test_gain_step();
		hold_keys(1'b1, 1'b0, 1'b1, 1'b0, 3 * audio_pkg::gain_repeat_cycles + 1);
		exp_pre = exp_pre + 4 * audio_pkg::gain_step;
		check_gain("pre_gain", pre_gain, exp_pre);
		check_gain("post_gain", post_gain, exp_post);
		hold_keys(1'b0, 1'b1, 1'b0, 1'b1, 2 * audio_pkg::gain_repeat_cycles + 1);
		exp_post = exp_post - 3 * audio_pkg::gain_step;
		check_gain("post_gain", post_gain, exp_post);
		check_gain("pre_gain", pre_gain, exp_pre);
	endtask

	task automatic test_gain_path();
		audio_pkg::sample_t expected;
		repeat (4) begin
			run_sample(audio_pkg::sample_t'($urandom()), expected);
			decode_frame(expected);
		end
	endtask

	task automatic test_bypass();
		audio_pkg::sample_t expected;
		bypass = 1'b1;
		run_sample(audio_pkg::sample_t'($urandom()), expected);
		run_sample(16'sd30000, expected);
		bypass = 1'b0;
	endtask

	task automatic test_gain_floor();
		hold_keys(1'b0, 1'b1, 1'b0, 1'b1, 20 * audio_pkg::gain_repeat_cycles);
		exp_post = '0; // Saturated well before the keys drop
		check_gain("post_gain", post_gain, exp_post);
		check_gain("pre_gain", pre_gain, exp_pre);
	endtask

	initial begin
		void'($urandom(32'h98c8_fd53));
		rst = 1'b1;
		pre_step_enable = 1'b0;
		post_step_enable = 1'b0;
		up = 1'b0;
		down = 1'b0;
		overdrive = 1'b0;
		bypass = 1'b0;
		sample_in = '0;
		exp_pre = audio_pkg::unity_gain;
		exp_post = audio_pkg::unity_gain;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		test_reset_state();
		test_overdrive();
		test_gain_step();
		test_gain_path();
		test_bypass();
		test_gain_floor();
		if (dut_i.i2s_i.props_i.violation) begin
			abort("An I2S timing assertion failed during the run");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

`default_nettype wire
